// ==== design/tenyr_video_pkg.sv ====
package tenyr_video_pkg;

    localparam int bus_width = 32;

    // Memory map.
    localparam logic [bus_width-1:0] seg7_addr  = 32'h0000_0100;
    localparam logic [bus_width-1:0] video_addr = 32'h0000_0200;
    localparam logic [bus_width-1:0] text_base  = video_addr + 32'h10;

    // Control register fields.
    localparam int ctl_display_bit = 0;
    localparam int ctl_cursor_bit  = 1;
    localparam int ctl_fg_lsb      = 2;
    localparam int ctl_bg_lsb      = 5;
    // Display on, cursor on, white on black.
    localparam logic [7:0] ctl_default = 8'b000_111_11;

    localparam int glyph_rows  = 8;
    localparam int glyph_cols  = 8;
    // Width of the raster pixel and line coordinates.
    localparam int coord_width = 12;

endpackage

// ==== design/mmr_bank.sv ====
`timescale 1ns/100ps

module mmr_bank #(
    parameter int cols = 80,
    parameter int rows = 40
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  rw,
    input  logic [tenyr_video_pkg::bus_width-1:0] addr,
    input  logic [tenyr_video_pkg::bus_width-1:0] wdata,
    output logic [tenyr_video_pkg::bus_width-1:0] rdata,
    output logic                                  text_we,
    output logic [$clog2(cols*rows)-1:0]          text_addr,
    output logic [7:0]                            text_wdata,
    input  logic [7:0]                            text_rdata,
    output logic [7:0]                            ctl,
    output logic [7:0]                            cur_x,
    output logic [7:0]                            cur_y,
    output logic [15:0]                           seg_value
);
    import tenyr_video_pkg::*;

    localparam int cells = cols * rows;

    logic [bus_width-1:0] offset;
    logic                 in_text;
    logic [bus_width-1:0] reg_next;
    logic [bus_width-1:0] reg_q;
    logic                 text_sel;

    assign offset     = addr - text_base;
    assign in_text    = (addr >= text_base) && (offset < cells);
    assign text_we    = rw && in_text;
    assign text_addr  = offset[$clog2(cells)-1:0];
    assign text_wdata = wdata[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl       <= ctl_default;
            cur_x     <= '0;
            cur_y     <= '0;
            seg_value <= '0;
        end else if (rw) begin
            case (addr)
                video_addr:          ctl       <= wdata[7:0];
                video_addr + 32'd1:  cur_x     <= wdata[7:0];
                video_addr + 32'd2:  cur_y     <= wdata[7:0];
                seg7_addr:           seg_value <= wdata[15:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        reg_next = '0;
        case (addr)
            video_addr:         reg_next[7:0]  = ctl;
            video_addr + 32'd1: reg_next[7:0]  = cur_x;
            video_addr + 32'd2: reg_next[7:0]  = cur_y;
            seg7_addr:          reg_next[15:0] = seg_value;
            default: ;
        endcase
    end

    // Text data comes straight from the RAM port, already one cycle late.
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_q    <= '0;
            text_sel <= 1'b0;
        end else begin
            reg_q    <= rw ? '0 : reg_next;
            text_sel <= !rw && in_text;
        end
    end

    assign rdata = text_sel ? {{(bus_width - 8){1'b0}}, text_rdata} : reg_q;

endmodule

// ==== design/text_ram.sv ====
`timescale 1ns/100ps

module text_ram #(
    parameter int cols = 80,
    parameter int rows = 40
) (
    input  logic                         clk,
    input  logic                         text_we,
    input  logic [$clog2(cols*rows)-1:0] text_addr,
    input  logic [7:0]                   text_wdata,
    output logic [7:0]                   text_rdata,
    input  logic [$clog2(cols*rows)-1:0] vid_addr,
    output logic [7:0]                   vid_char
);

    logic [7:0] mem [cols*rows];

    // Bus port.
    always_ff @(posedge clk) begin
        if (text_we) begin
            mem[text_addr] <= text_wdata;
        end
        text_rdata <= mem[text_addr];
    end

    // Video port.
    always_ff @(posedge clk) begin
        vid_char <= mem[vid_addr];
    end

endmodule

// ==== design/font_rom.sv ====
`timescale 1ns/100ps

module font_rom (
    input  logic       clk,
    input  logic [5:0] font_addr,
    output logic [7:0] font_row
);

    // Eight glyphs of eight rows, bit 7 leftmost.
    logic [7:0] rom [64];

    initial begin
        $readmemh("font.hex", rom);
    end

    always_ff @(posedge clk) begin
        font_row <= rom[font_addr];
    end

endmodule

// ==== design/raster_timing.sv ====
`timescale 1ns/100ps

module raster_timing #(
    parameter int cols    = 80,
    parameter int rows    = 40,
    parameter int h_front = 16,
    parameter int h_sync  = 96,
    parameter int h_back  = 48,
    parameter int v_front = 10,
    parameter int v_sync  = 2,
    parameter int v_back  = 33
) (
    input  logic                                    clk,
    input  logic                                    reset,
    output logic [tenyr_video_pkg::coord_width-1:0] px,
    output logic [tenyr_video_pkg::coord_width-1:0] py,
    output logic                                    active,
    output logic                                    hsync,
    output logic                                    vsync
);
    import tenyr_video_pkg::*;

    localparam logic [coord_width-1:0] h_active = coord_width'(cols * glyph_cols);
    localparam logic [coord_width-1:0] hs_start = coord_width'(cols * glyph_cols + h_front);
    localparam logic [coord_width-1:0] hs_end   = hs_start + coord_width'(h_sync);
    localparam logic [coord_width-1:0] h_total  = hs_end + coord_width'(h_back);
    localparam logic [coord_width-1:0] v_active = coord_width'(rows * glyph_rows);
    localparam logic [coord_width-1:0] vs_start = coord_width'(rows * glyph_rows + v_front);
    localparam logic [coord_width-1:0] vs_end   = vs_start + coord_width'(v_sync);
    localparam logic [coord_width-1:0] v_total  = vs_end + coord_width'(v_back);

    logic [coord_width-1:0] hcnt;
    logic [coord_width-1:0] vcnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == h_total - 1'b1) begin
            hcnt <= '0;
            vcnt <= (vcnt == v_total - 1'b1) ? '0 : vcnt + 1'b1;
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
        end else begin
            active <= (hcnt < h_active) && (vcnt < v_active);
            hsync  <= !((hcnt >= hs_start) && (hcnt < hs_end));
            vsync  <= !((vcnt >= vs_start) && (vcnt < vs_end));
        end
    end

    always_ff @(posedge clk) begin
        px <= hcnt;
        py <= vcnt;
    end

endmodule

// ==== design/text_fetch.sv ====
`timescale 1ns/100ps

module text_fetch #(
    parameter int cols = 80,
    parameter int rows = 40
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [tenyr_video_pkg::coord_width-1:0] px,
    input  logic [tenyr_video_pkg::coord_width-1:0] py,
    input  logic                                    active,
    input  logic                                    hsync,
    input  logic                                    vsync,
    input  logic [7:0]                              vid_char,
    output logic [$clog2(cols*rows)-1:0]            vid_addr,
    output logic [7:0]                              char_code,
    output logic [2:0]                              glyph_row,
    output logic [2:0]                              glyph_col,
    output logic [7:0]                              cell_x,
    output logic [7:0]                              cell_y,
    output logic                                    active_out,
    output logic                                    hsync_out,
    output logic                                    vsync_out
);
    import tenyr_video_pkg::*;

    localparam int aw     = $clog2(cols * rows);
    localparam int col_sh = $clog2(glyph_cols);
    localparam int row_sh = $clog2(glyph_rows);

    logic [7:0] cx;
    logic [7:0] cy;
    logic [2:0] row_q;
    logic [2:0] col_q;
    logic [7:0] cx_q;
    logic [7:0] cy_q;
    logic [2:0] ctl_q;

    assign cx = px[col_sh +: 8];
    assign cy = py[row_sh +: 8];

    // First cycle registers the cell address, second is the RAM read.
    always_ff @(posedge clk) begin
        vid_addr  <= aw'(cy * cols + cx);
        row_q     <= py[row_sh-1:0];
        col_q     <= px[col_sh-1:0];
        cx_q      <= cx;
        cy_q      <= cy;
        glyph_row <= row_q;
        glyph_col <= col_q;
        cell_x    <= cx_q;
        cell_y    <= cy_q;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_q                              <= 3'b011;
            {active_out, hsync_out, vsync_out} <= 3'b011;
        end else begin
            ctl_q                              <= {active, hsync, vsync};
            {active_out, hsync_out, vsync_out} <= ctl_q;
        end
    end

    assign char_code = vid_char;

endmodule

// ==== design/glyph_render.sv ====
`timescale 1ns/100ps

module glyph_render (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] char_code,
    input  logic [2:0] glyph_row,
    input  logic [2:0] glyph_col,
    input  logic [7:0] cell_x,
    input  logic [7:0] cell_y,
    input  logic       active,
    input  logic       hsync,
    input  logic       vsync,
    input  logic [7:0] font_row,
    input  logic [7:0] ctl,
    input  logic [7:0] cur_x,
    input  logic [7:0] cur_y,
    output logic [5:0] font_addr,
    output logic       red,
    output logic       green,
    output logic       blue,
    output logic       hsync_out,
    output logic       vsync_out
);
    import tenyr_video_pkg::*;

    logic [2:0] col_q;
    logic       cursor_q;
    logic       active_q;
    logic       hsync_q;
    logic       vsync_q;
    logic       pixel;
    logic [2:0] rgb;

    assign font_addr = {char_code[2:0], glyph_row};

    // Side signals wait here while the ROM is read.
    always_ff @(posedge clk) begin
        col_q    <= glyph_col;
        cursor_q <= (cell_x == cur_x) && (cell_y == cur_y);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            hsync_q  <= 1'b1;
            vsync_q  <= 1'b1;
        end else begin
            active_q <= active;
            hsync_q  <= hsync;
            vsync_q  <= vsync;
        end
    end

    always_comb begin
        pixel = font_row[3'd7 - col_q] ^ (cursor_q && ctl[ctl_cursor_bit]);
        rgb   = pixel ? ctl[ctl_fg_lsb +: 3] : ctl[ctl_bg_lsb +: 3];
        if (!active_q || !ctl[ctl_display_bit]) begin
            rgb = 3'b000;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            {red, green, blue}     <= 3'b000;
            {hsync_out, vsync_out} <= 2'b11;
        end else begin
            {red, green, blue}     <= rgb;
            {hsync_out, vsync_out} <= {hsync_q, vsync_q};
        end
    end

endmodule

// ==== design/seg7_scan.sv ====
`timescale 1ns/100ps

module seg7_scan #(
    parameter int scan_div = 50000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] seg_value,
    output logic [7:0]  seg,
    output logic [3:0]  an
);

    logic [$clog2(scan_div+1)-1:0] div;
    logic [1:0]                    digit;

    // Segments gfedcba, active high.
    function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'h3f;
            4'h1: return 7'h06;
            4'h2: return 7'h5b;
            4'h3: return 7'h4f;
            4'h4: return 7'h66;
            4'h5: return 7'h6d;
            4'h6: return 7'h7d;
            4'h7: return 7'h07;
            4'h8: return 7'h7f;
            4'h9: return 7'h6f;
            4'ha: return 7'h77;
            4'hb: return 7'h7c;
            4'hc: return 7'h39;
            4'hd: return 7'h5e;
            4'he: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            div   <= '0;
            digit <= '0;
            seg   <= 8'hff;
            an    <= 4'hf;
        end else begin
            if (div == scan_div - 1) begin
                div   <= '0;
                digit <= digit + 1'b1;
            end else begin
                div <= div + 1'b1;
            end
            // Decimal point stays dark.
            seg <= {1'b1, ~hex_to_seg(seg_value[digit*4 +: 4])};
            an  <= ~(4'b0001 << digit);
        end
    end

endmodule

// ==== design/tenyr_video.sv ====
`timescale 1ns/100ps

module tenyr_video #(
    parameter int cols     = 80,
    parameter int rows     = 40,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33,
    parameter int scan_div = 50000
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  rw,
    input  logic [tenyr_video_pkg::bus_width-1:0] addr,
    input  logic [tenyr_video_pkg::bus_width-1:0] wdata,
    output logic [tenyr_video_pkg::bus_width-1:0] rdata,
    output logic                                  red,
    output logic                                  green,
    output logic                                  blue,
    output logic                                  hsync,
    output logic                                  vsync,
    output logic [7:0]                            seg,
    output logic [3:0]                            an
);
    import tenyr_video_pkg::*;

    localparam int aw = $clog2(cols * rows);

    logic          text_we;
    logic [aw-1:0] text_addr;
    logic [7:0]    text_wdata;
    logic [7:0]    text_rdata;
    logic [7:0]    ctl;
    logic [7:0]    cur_x;
    logic [7:0]    cur_y;
    logic [15:0]   seg_value;

    logic [coord_width-1:0] px;
    logic [coord_width-1:0] py;
    logic                   r_active;
    logic                   r_hsync;
    logic                   r_vsync;

    logic [aw-1:0] vid_addr;
    logic [7:0]    vid_char;
    logic [7:0]    char_code;
    logic [2:0]    glyph_row;
    logic [2:0]    glyph_col;
    logic [7:0]    cell_x;
    logic [7:0]    cell_y;
    logic          f_active;
    logic          f_hsync;
    logic          f_vsync;
    logic [5:0]    font_addr;
    logic [7:0]    font_row;

    mmr_bank #(.cols(cols), .rows(rows)) bank (
        .clk(clk), .reset(reset), .rw(rw), .addr(addr), .wdata(wdata), .rdata(rdata),
        .text_we(text_we), .text_addr(text_addr), .text_wdata(text_wdata),
        .text_rdata(text_rdata), .ctl(ctl), .cur_x(cur_x), .cur_y(cur_y),
        .seg_value(seg_value)
    );

    text_ram #(.cols(cols), .rows(rows)) text (
        .clk(clk), .text_we(text_we), .text_addr(text_addr), .text_wdata(text_wdata),
        .text_rdata(text_rdata), .vid_addr(vid_addr), .vid_char(vid_char)
    );

    font_rom font (
        .clk(clk), .font_addr(font_addr), .font_row(font_row)
    );

    raster_timing #(
        .cols(cols), .rows(rows), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) raster (
        .clk(clk), .reset(reset), .px(px), .py(py), .active(r_active),
        .hsync(r_hsync), .vsync(r_vsync)
    );

    text_fetch #(.cols(cols), .rows(rows)) fetch (
        .clk(clk), .reset(reset), .px(px), .py(py), .active(r_active), .hsync(r_hsync),
        .vsync(r_vsync), .vid_char(vid_char), .vid_addr(vid_addr), .char_code(char_code),
        .glyph_row(glyph_row), .glyph_col(glyph_col), .cell_x(cell_x), .cell_y(cell_y),
        .active_out(f_active), .hsync_out(f_hsync), .vsync_out(f_vsync)
    );

    glyph_render render (
        .clk(clk), .reset(reset), .char_code(char_code), .glyph_row(glyph_row),
        .glyph_col(glyph_col), .cell_x(cell_x), .cell_y(cell_y), .active(f_active),
        .hsync(f_hsync), .vsync(f_vsync), .font_row(font_row), .ctl(ctl), .cur_x(cur_x),
        .cur_y(cur_y), .font_addr(font_addr), .red(red), .green(green), .blue(blue),
        .hsync_out(hsync), .vsync_out(vsync)
    );

    seg7_scan #(.scan_div(scan_div)) seg7 (
        .clk(clk), .reset(reset), .seg_value(seg_value), .seg(seg), .an(an)
    );

endmodule

// ==== tb/tenyr_video_tb.sv ====
`timescale 1ns/100ps

module tenyr_video_tb;
    import tenyr_video_pkg::*;

    localparam int cols        = 4;
    localparam int rows        = 3;
    localparam int h_front     = 2;
    localparam int h_sync      = 4;
    localparam int h_back      = 2;
    localparam int v_front     = 1;
    localparam int v_sync      = 2;
    localparam int v_back      = 1;
    localparam int scan_div    = 4;
    localparam int cells       = cols * rows;
    localparam int line_len    = cols * glyph_cols + h_front + h_sync + h_back;
    localparam int frame_lines = rows * glyph_rows + v_front + v_sync + v_back;
    // Reset and bus phase plus seven frames of video, doubled.
    localparam int limit_cycles = 2 * (300 + 7 * line_len * frame_lines);

    logic                 clk;
    logic                 reset;
    logic                 rw;
    logic [bus_width-1:0] addr;
    logic [bus_width-1:0] wdata;
    logic [bus_width-1:0] rdata;
    logic                 red;
    logic                 green;
    logic                 blue;
    logic                 hsync;
    logic                 vsync;
    logic [7:0]           seg;
    logic [3:0]           an;

    // Reference copies of the DUT state.
    logic [7:0]           text_copy [cells];
    logic [7:0]           font_copy [64];
    logic [7:0]           ctl_copy = ctl_default;
    logic [7:0]           cur_x_copy = '0;
    logic [7:0]           cur_y_copy = '0;
    logic [15:0]          seg_copy = '0;
    logic [15:0]          seg_d1;
    logic [15:0]          seg_d2;
    logic [bus_width-1:0] exp_rdata;
    logic [bus_width-1:0] exp_rdata_q;
    logic [4:0]           exp_video;
    logic [4:0][4:0]      exp_pipe;
    logic                 video_check = 1'b0;
    int                   hm = 0;
    int                   vm = 0;
    int                   quiet = 0;
    int                   run_cycles = 0;
    int                   rdata_errors = 0;
    int                   video_errors = 0;
    int                   seg_errors = 0;
    int                   seed = 32'hd441_f084;
    int                   i;

    tenyr_video #(
        .cols(cols), .rows(rows), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_front(v_front), .v_sync(v_sync), .v_back(v_back), .scan_div(scan_div)
    ) dut (
        .clk(clk), .reset(reset), .rw(rw), .addr(addr), .wdata(wdata), .rdata(rdata),
        .red(red), .green(green), .blue(blue), .hsync(hsync), .vsync(vsync),
        .seg(seg), .an(an)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        $readmemh("font.hex", font_copy);
    end

    // Expected {red, green, blue, hsync, vsync} for one raster position.
    function automatic logic [4:0] video_model(input int h, input int v);
        logic [2:0] rgb;
        logic       hs;
        logic       vs;
        logic       pix;
        logic [7:0] ch;
        int         cx;
        int         cy;
        hs  = !(h >= cols * glyph_cols + h_front && h < cols * glyph_cols + h_front + h_sync);
        vs  = !(v >= rows * glyph_rows + v_front && v < rows * glyph_rows + v_front + v_sync);
        rgb = 3'b000;
        if (h < cols * glyph_cols && v < rows * glyph_rows && ctl_copy[ctl_display_bit]) begin
            cx  = h / glyph_cols;
            cy  = v / glyph_rows;
            ch  = text_copy[cy * cols + cx];
            pix = font_copy[ch[2:0] * glyph_rows + v % glyph_rows][7 - h % glyph_cols];
            if (ctl_copy[ctl_cursor_bit] && cx == cur_x_copy && cy == cur_y_copy) begin
                pix = !pix;
            end
            rgb = pix ? ctl_copy[ctl_fg_lsb +: 3] : ctl_copy[ctl_bg_lsb +: 3];
        end
        return {rgb, hs, vs};
    endfunction

    // Common-anode patterns, decimal point dark.
    function automatic logic [7:0] seg_model(input logic [3:0] an_v, input logic [15:0] value);
        logic [7:0] pat [16];
        logic [3:0] nib;
        int         k;
        pat = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
                8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};
        nib = value[3:0];
        for (k = 0; k < 4; k++) begin
            if (!an_v[k]) begin
                nib = value[k*4 +: 4];
            end
        end
        return pat[nib];
    endfunction

    always_comb begin
        exp_video = video_model(hm, vm);
        exp_rdata = '0;
        if (!rw) begin
            if (addr == video_addr) begin
                exp_rdata[7:0] = ctl_copy;
            end else if (addr == video_addr + 1) begin
                exp_rdata[7:0] = cur_x_copy;
            end else if (addr == video_addr + 2) begin
                exp_rdata[7:0] = cur_y_copy;
            end else if (addr == seg7_addr) begin
                exp_rdata[15:0] = seg_copy;
            end else if (addr >= text_base && addr < text_base + cells) begin
                exp_rdata[7:0] = text_copy[addr - text_base];
            end
        end
    end

    // Raster position from the line and frame lengths.
    always @(posedge clk) begin
        if (reset) begin
            hm <= 0;
            vm <= 0;
        end else if (hm == line_len - 1) begin
            hm <= 0;
            vm <= (vm == frame_lines - 1) ? 0 : vm + 1;
        end else begin
            hm <= hm + 1;
        end
        quiet       <= (reset || rw) ? 0 : quiet + 1;
        run_cycles  <= reset ? 0 : run_cycles + 1;
        exp_rdata_q <= exp_rdata;
        exp_pipe    <= {exp_pipe[3:0], exp_video};
        seg_d1      <= seg_copy;
        seg_d2      <= seg_d1;
    end

    rdata_check: assert property (@(posedge clk) disable iff (reset) rdata == exp_rdata_q)
        else begin
            rdata_errors++;
            $display("Fail %0t: rdata %h, expected %h", $time, $sampled(rdata),
                     $sampled(exp_rdata_q));
        end

    sync_check: assert property (@(posedge clk) disable iff (reset)
        {hsync, vsync} == exp_pipe[4][1:0])
        else begin
            video_errors++;
            $display("Fail %0t: syncs %b, expected %b", $time,
                     $sampled({hsync, vsync}), $sampled(exp_pipe[4][1:0]));
        end

    pixel_check: assert property (@(posedge clk) disable iff (reset || quiet < 8 || !video_check)
        {red, green, blue} == exp_pipe[4][4:2])
        else begin
            video_errors++;
            $display("Fail %0t: rgb %b, expected %b", $time,
                     $sampled({red, green, blue}), $sampled(exp_pipe[4][4:2]));
        end

    scan_check: assert property (@(posedge clk) disable iff (reset || run_cycles < 4)
        $onehot(~an) && seg == seg_model(an, seg_d2))
        else begin
            seg_errors++;
            $display("Fail %0t: seg %h with an %b, value %h", $time, $sampled(seg),
                     $sampled(an), $sampled(seg_d2));
        end

    task automatic bus_write(input logic [bus_width-1:0] a, input logic [bus_width-1:0] d);
        @(posedge clk);
        #1;
        rw    = 1'b1;
        addr  = a;
        wdata = d;
        if (a == video_addr) begin
            ctl_copy = d[7:0];
        end else if (a == video_addr + 1) begin
            cur_x_copy = d[7:0];
        end else if (a == video_addr + 2) begin
            cur_y_copy = d[7:0];
        end else if (a == seg7_addr) begin
            seg_copy = d[15:0];
        end else if (a >= text_base && a < text_base + cells) begin
            text_copy[a - text_base] = d[7:0];
        end
    endtask

    task automatic bus_read(input logic [bus_width-1:0] a);
        @(posedge clk);
        #1;
        rw   = 1'b0;
        addr = a;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #1;
        rw    = 1'b0;
        addr  = '0;
        wdata = '0;
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(negedge vsync);
    endtask

    initial begin
        reset = 1'b1;
        rw    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        // Defaults, an unmapped address, then writes with readback.
        bus_read(video_addr);
        bus_read(video_addr + 1);
        bus_read(video_addr + 2);
        bus_read(seg7_addr);
        bus_read(32'h0000_0300);
        bus_write(video_addr, 32'h0000_003b);
        bus_read(video_addr);
        bus_write(video_addr + 1, 32'h0000_0002);
        bus_read(video_addr + 1);
        bus_write(video_addr + 2, 32'h0000_0001);
        bus_read(video_addr + 2);
        bus_write(seg7_addr, $random(seed));
        bus_read(seg7_addr);
        bus_write(32'h0000_0104, 32'hdead_beef);
        bus_read(32'h0000_0104);
        for (i = 0; i < cells; i++) begin
            bus_write(text_base + i, $random(seed));
        end
        for (i = 0; i <= cells; i++) begin
            bus_read(text_base + i);
        end
        bus_idle();
        video_check = 1'b1;
        wait_frames(2);
        // Display off.
        bus_write(video_addr, 32'h0000_003a);
        bus_idle();
        wait_frames(2);
        // Display back on with the cursor in another cell.
        bus_write(video_addr, 32'h0000_003b);
        bus_write(video_addr + 1, 32'h0000_0000);
        bus_write(video_addr + 2, 32'h0000_0002);
        bus_write(seg7_addr, $random(seed));
        bus_idle();
        wait_frames(2);
        // Cursor off.
        bus_write(video_addr, 32'h0000_0039);
        bus_idle();
        wait_frames(1);
        $display("rdata errors %0d, video errors %0d, segment errors %0d",
                 rdata_errors, video_errors, seg_errors);
        if (rdata_errors + video_errors + seg_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(limit_cycles * 10);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== font.hex ====
// Eight rows per glyph as hex bytes with bit 7 the leftmost pixel.
3c
66
6e
76
66
66
3c
00
18
38
18
18
18
18
7e
00
18
3c
66
66
7e
66
66
00
7c
66
66
7c
66
66
7c
00
3c
66
60
60
60
66
3c
00
aa
55
aa
55
aa
55
aa
55
ff
81
81
81
81
81
81
ff
80
40
20
10
08
04
02
01

// ==== tenyr_video.f ====
design/tenyr_video_pkg.sv
design/mmr_bank.sv
design/text_ram.sv
design/font_rom.sv
design/raster_timing.sv
design/text_fetch.sv
design/glyph_render.sv
design/seg7_scan.sv
design/tenyr_video.sv
tb/tenyr_video_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tenyr_video_tb \
    -f tenyr_video.f -o tenyr_video_sim &&
./obj_dir/tenyr_video_sim | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null &&
echo "Simulation passed." ||
{ echo "Simulation failed."; exit 1; }
